/* common/ciPkg.sv */
`default_nettype none

package ciPkg;

  // Operand and result width.
  localparam int ciWordWidth = 32;

  // Instruction number width.
  localparam int ciNumWidth = 8;

  // Opcodes carry their instruction number as encoding.
  typedef enum logic [ciNumWidth-1:0] {
    ciOpNone  = 8'd0,
    ciOpSwap  = 8'd1,
    ciOpDelay = 8'd6,
    ciOpGray  = 8'd9
  } ciOp;

  // System clock cycles per delay tick.
  localparam int delayTickCycles = 4;
  localparam int delayPrescaleWidth = $clog2(delayTickCycles);

  // Only the low bits of operand A set the tick count.
  localparam int delayCountWidth = 16;

endpackage

`default_nettype wire

/* common/pixelPkg.sv */
`default_nettype none

package pixelPkg;

  // RGB565 field widths, red in the top bits.
  localparam int redBits   = 5;
  localparam int greenBits = 6;
  localparam int blueBits  = 5;

  // Luminance weights, scaled so they sum to 256.
  localparam int unsigned grayWeightRed   = 54;
  localparam int unsigned grayWeightGreen = 183;
  localparam int unsigned grayWeightBlue  = 19;

  // Width of one widened channel and of the gray value.
  localparam int grayWidth = 8;

endpackage

`default_nettype wire

/* common/ciReqIf.sv */
`default_nettype none
`timescale 1ns/1ps

interface ciReqIf;
  import ciPkg::*;

  // Strobe, payload valid only while start is high.
  logic                   start;
  ciOp                    op;
  logic [ciWordWidth-1:0] dataA;
  logic [ciWordWidth-1:0] dataB;

  modport source (
    output start, op, dataA, dataB
  );

  modport unit (
    input start, op, dataA, dataB
  );

endinterface

`default_nettype wire

/* verilog/ciDecode.sv */
`default_nettype none
`timescale 1ns/1ps

module ciDecode (
  input  wire logic                          systemClock,
  input  wire logic                          rstN,
  input  wire logic                          ciStart,
  input  wire logic [ciPkg::ciNumWidth-1:0]  ciN,
  input  wire logic [ciPkg::ciWordWidth-1:0] ciDataA,
  input  wire logic [ciPkg::ciWordWidth-1:0] ciDataB,
  ciReqIf.source                             req
);
  import ciPkg::*;

  ciOp decodedOp;

  // Unknown numbers fall through to ciOpNone.
  always_comb begin
    case (ciN)
      ciOpSwap:  decodedOp = ciOpSwap;
      ciOpDelay: decodedOp = ciOpDelay;
      ciOpGray:  decodedOp = ciOpGray;
      default:   decodedOp = ciOpNone;
    endcase
  end

  always_ff @(posedge systemClock or negedge rstN) begin
    if (!rstN) begin
      req.start <= 1'b0;
    end else begin
      req.start <= ciStart;
    end
  end

  // Payload only moves on a start.
  always_ff @(posedge systemClock) begin
    if (ciStart) begin
      req.op    <= decodedOp;
      req.dataA <= ciDataA;
      req.dataB <= ciDataB;
    end
  end

endmodule

`default_nettype wire

/* ise/dataIse.sv */
`default_nettype none
`timescale 1ns/1ps

module dataIse (
  input  wire logic                     systemClock,
  input  wire logic                     rstN,
  ciReqIf.unit                          req,
  output logic                          done,
  output logic [ciPkg::ciWordWidth-1:0] result
);
  import ciPkg::*;
  import pixelPkg::*;

  logic [grayWidth-1:0]   redWide;
  logic [grayWidth-1:0]   greenWide;
  logic [grayWidth-1:0]   blueWide;
  logic [2*grayWidth-1:0] weightedSum;
  logic [grayWidth-1:0]   grayValue;
  logic [ciWordWidth-1:0] swapped;
  logic                   nextDone;
  logic [ciWordWidth-1:0] nextResult;

  assign swapped = {req.dataA[7:0], req.dataA[15:8], req.dataA[23:16], req.dataA[31:24]};

  // RGB565 channels padded with zeros to 8 bits.
  assign redWide   = {req.dataA[blueBits+greenBits +: redBits], {(grayWidth-redBits){1'b0}}};
  assign greenWide = {req.dataA[blueBits +: greenBits], {(grayWidth-greenBits){1'b0}}};
  assign blueWide  = {req.dataA[0 +: blueBits], {(grayWidth-blueBits){1'b0}}};

  // Weights sum to 256, so the top byte is the gray level.
  assign weightedSum = (2*grayWidth)'(grayWeightRed * redWide +
                                      grayWeightGreen * greenWide +
                                      grayWeightBlue * blueWide);
  assign grayValue = weightedSum[2*grayWidth-1:grayWidth];

  always_comb begin
    nextDone   = 1'b0;
    nextResult = '0;
    if (req.start) begin
      case (req.op)
        ciOpSwap: begin
          nextDone   = 1'b1;
          nextResult = swapped;
        end
        ciOpGray: begin
          nextDone   = 1'b1;
          nextResult = {{(ciWordWidth-grayWidth){1'b0}}, grayValue};
        end
        default: begin
          nextDone   = 1'b0;
          nextResult = '0;
        end
      endcase
    end
  end

  always_ff @(posedge systemClock or negedge rstN) begin
    if (!rstN) begin
      done   <= 1'b0;
      result <= '0;
    end else begin
      done   <= nextDone;
      result <= nextResult;
    end
  end

endmodule

`default_nettype wire

/* ise/delayIse.sv */
`default_nettype none
`timescale 1ns/1ps

module delayIse (
  input  wire logic                     systemClock,
  input  wire logic                     rstN,
  ciReqIf.unit                          req,
  output logic                          done,
  output logic [ciPkg::ciWordWidth-1:0] result
);
  import ciPkg::*;

  typedef enum logic {
    delayIdle,
    delayCounting
  } delayState;

  delayState                     state;
  logic [delayPrescaleWidth-1:0] prescaler;
  logic                          tick;
  logic [delayCountWidth-1:0]    ticksLeft;
  logic [delayCountWidth-1:0]    loadCount;

  // A zero count still waits one tick.
  assign loadCount = (req.dataA[delayCountWidth-1:0] == '0) ?
                     delayCountWidth'(1) : req.dataA[delayCountWidth-1:0];

  assign tick = (prescaler == delayPrescaleWidth'(delayTickCycles - 1));

  // Delay answers carry no data.
  assign result = '0;

  // Free running, so the first tick lands anywhere in one period.
  always_ff @(posedge systemClock or negedge rstN) begin
    if (!rstN) begin
      prescaler <= '0;
    end else if (tick) begin
      prescaler <= '0;
    end else begin
      prescaler <= prescaler + 1'b1;
    end
  end

  always_ff @(posedge systemClock or negedge rstN) begin
    if (!rstN) begin
      state     <= delayIdle;
      ticksLeft <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        delayIdle: begin
          if (req.start && req.op == ciOpDelay) begin
            ticksLeft <= loadCount;
            state     <= delayCounting;
          end
        end
        delayCounting: begin
          if (tick) begin
            ticksLeft <= ticksLeft - 1'b1;
            if (ticksLeft == delayCountWidth'(1)) begin
              done  <= 1'b1;
              state <= delayIdle;
            end
          end
        end
        default: state <= delayIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/ciMerge.sv */
`default_nettype none
`timescale 1ns/1ps

module ciMerge (
  input  wire logic                          systemClock,
  input  wire logic                          rstN,
  ciReqIf.unit                               req,
  input  wire logic                          dataDone,
  input  wire logic [ciPkg::ciWordWidth-1:0] dataResult,
  input  wire logic                          delayDone,
  input  wire logic [ciPkg::ciWordWidth-1:0] delayResult,
  output logic                               ciDone,
  output logic [ciPkg::ciWordWidth-1:0]      ciResult
);
  import ciPkg::*;

  logic                   noneDone;
  logic                   mergedDone;
  logic [ciWordWidth-1:0] mergedResult;

  // Answer for unknown numbers, timed like the data unit.
  always_ff @(posedge systemClock or negedge rstN) begin
    if (!rstN) begin
      noneDone <= 1'b0;
    end else begin
      noneDone <= req.start && (req.op == ciOpNone);
    end
  end

  // Idle units drive zero, so a plain OR selects the answer.
  assign mergedDone   = dataDone | delayDone | noneDone;
  assign mergedResult = dataResult | delayResult;

  always_ff @(posedge systemClock or negedge rstN) begin
    if (!rstN) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= mergedDone;
      ciResult <= mergedResult;
    end
  end

endmodule

`default_nettype wire

/* verilog/ciHub.sv */
`default_nettype none
`timescale 1ns/1ps

module ciHub (
  input  wire logic                          systemClock,
  input  wire logic                          rstN,
  input  wire logic                          ciStart,
  input  wire logic [ciPkg::ciNumWidth-1:0]  ciN,
  input  wire logic [ciPkg::ciWordWidth-1:0] ciDataA,
  input  wire logic [ciPkg::ciWordWidth-1:0] ciDataB,
  output logic                               ciDone,
  output logic [ciPkg::ciWordWidth-1:0]      ciResult
);
  import ciPkg::*;

  logic                   dataDone;
  logic [ciWordWidth-1:0] dataResult;
  logic                   delayDone;
  logic [ciWordWidth-1:0] delayResult;

  ciReqIf reqIf ();

  ciDecode u_ciDecode (
    .systemClock (systemClock),
    .rstN        (rstN),
    .ciStart     (ciStart),
    .ciN         (ciN),
    .ciDataA     (ciDataA),
    .ciDataB     (ciDataB),
    .req         (reqIf.source)
  );

  dataIse u_dataIse (
    .systemClock (systemClock),
    .rstN        (rstN),
    .req         (reqIf.unit),
    .done        (dataDone),
    .result      (dataResult)
  );

  delayIse u_delayIse (
    .systemClock (systemClock),
    .rstN        (rstN),
    .req         (reqIf.unit),
    .done        (delayDone),
    .result      (delayResult)
  );

  ciMerge u_ciMerge (
    .systemClock (systemClock),
    .rstN        (rstN),
    .req         (reqIf.unit),
    .dataDone    (dataDone),
    .dataResult  (dataResult),
    .delayDone   (delayDone),
    .delayResult (delayResult),
    .ciDone      (ciDone),
    .ciResult    (ciResult)
  );

endmodule

`default_nettype wire

/* bench/ciHub_chk.sv */
`default_nettype none
`timescale 1ns/1ps

module ciHubChk (
  input wire logic                          systemClock,
  input wire logic                          rstN,
  input wire logic                          ciStart,
  input wire logic [ciPkg::ciNumWidth-1:0]  ciN,
  input wire logic                          ciDone,
  input wire logic [ciPkg::ciWordWidth-1:0] ciResult,
  input wire logic                          delayBusy
);
  import ciPkg::*;

  // A second done in a row must answer a start one cycle later.
  doneOneCycle: assert property (@(posedge systemClock) disable iff (!rstN)
    ciDone |=> !ciDone || $past(ciStart, 3)) else $error("ciDone held high without a new request");

  resultZeroIdle: assert property (@(posedge systemClock) disable iff (!rstN)
    !ciDone |-> ciResult == '0) else $error("ciResult nonzero while ciDone is low");

  noStartWhileDelay: assert property (@(posedge systemClock) disable iff (!rstN)
    ciStart |-> !delayBusy) else $error("ciStart issued while a delay is pending");

  // Everything except the delay answers at a fixed latency.
  fixedLatency: assert property (@(posedge systemClock) disable iff (!rstN)
    ciStart && ciN != ciOpDelay |-> ##3 ciDone) else $error("ciDone missing 3 cycles after start");

endmodule

// Delay FSM state reads 1 while counting.
bind ciHub ciHubChk u_ciHubChk (
  .systemClock (systemClock),
  .rstN        (rstN),
  .ciStart     (ciStart),
  .ciN         (ciN),
  .ciDone      (ciDone),
  .ciResult    (ciResult),
  .delayBusy   (u_delayIse.state)
);

`default_nettype wire

/* bench/ciHubTb.sv */
`default_nettype none
`timescale 1ns/1ps

module ciHubTb;

  localparam int clockPeriod = 100;
  localparam int resetCycles = 4;
  localparam int tickCycles = 4;
  localparam int burstLength = 16;
  localparam string stimFile = "bench/ciStim.txt";

  logic        systemClock;
  logic        rstN;
  logic        ciStart;
  logic [7:0]  ciN;
  logic [31:0] ciDataA;
  logic [31:0] ciDataB;
  logic        ciDone;
  logic [31:0] ciResult;

  int seed = 32'h33133b98;
  int errors = 0;
  int testCount = 0;
  int passCount = 0;
  int failCount = 0;
  bit stimLoaded = 1'b0;
  logic [7:0]  stimNum[$];
  logic [31:0] stimA[$];
  logic [31:0] stimB[$];
  logic [31:0] stimExp[$];

  ciHub u_ciHub (
    .systemClock (systemClock),
    .rstN        (rstN),
    .ciStart     (ciStart),
    .ciN         (ciN),
    .ciDataA     (ciDataA),
    .ciDataB     (ciDataB),
    .ciDone      (ciDone),
    .ciResult    (ciResult)
  );

  always #(clockPeriod / 2) systemClock = ~systemClock;

  function automatic logic [31:0] swapBytes(input logic [31:0] a);
    return {a[7:0], a[15:8], a[23:16], a[31:24]};
  endfunction

  // RGB565 widened to 8-bit channels, weights 54/183/19 over 256.
  function automatic logic [31:0] grayOf(input logic [31:0] a);
    int unsigned r;
    int unsigned g;
    int unsigned b;
    int unsigned sum;
    r = {24'h0, a[15:11], 3'b000};
    g = {24'h0, a[10:5], 2'b00};
    b = {24'h0, a[4:0], 3'b000};
    sum = 54 * r + 183 * g + 19 * b;
    return {24'h0, sum[15:8]};
  endfunction

  function automatic string opName(input logic [7:0] num);
    case (num)
      8'd1: return "swap";
      8'd6: return "delay";
      8'd9: return "gray";
      default: return "unknown";
    endcase
  endfunction

  task automatic closeTest(input string name, input int errorsBefore);
    if (errors == errorsBefore) begin
      passCount++;
      $display("Test %0d %s passed", testCount, name);
    end else begin
      failCount++;
      $display("Test %0d %s failed", testCount, name);
    end
  endtask

  task automatic loadStim();
    int fd;
    string line;
    logic [31:0] num;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expected;
    fd = $fopen(stimFile, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", stimFile);
      errors++;
    end else begin
      // Comment lines fail the scan and are skipped.
      while ($feof(fd) == 0) begin
        line = "";
        if ($fgets(line, fd) != 0 &&
            $sscanf(line, "%h %h %h %h", num, a, b, expected) == 4) begin
          stimNum.push_back(num[7:0]);
          stimA.push_back(a);
          stimB.push_back(b);
          stimExp.push_back(expected);
        end
      end
      $fclose(fd);
      stimLoaded = 1'b1;
    end
  endtask

  task automatic checkIdle(input string when);
    assert (ciDone === 1'b0 && ciResult === 32'h0) else begin
      $display("Fail at %0d ns: outputs not idle %s, ciDone %b ciResult %h",
               $time, when, ciDone, ciResult);
      errors++;
    end
  endtask

  task automatic checkReset();
    int errorsBefore;
    errorsBefore = errors;
    testCount++;
    repeat (resetCycles) begin
      @(negedge systemClock);
      checkIdle("in reset");
    end
    @(posedge systemClock);
    rstN <= 1'b1;
    repeat (4) begin
      @(negedge systemClock);
      checkIdle("after reset");
    end
    closeTest("reset", errorsBefore);
  endtask

  // Latency counts rising edges from the edge that samples ciStart.
  task automatic runTest(input logic [7:0] num, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] expected);
    int errorsBefore;
    int minLat;
    int maxLat;
    int lat;
    bit seen;
    errorsBefore = errors;
    testCount++;
    minLat = 3;
    maxLat = 3;
    if (num == 8'd6) begin
      minLat = (a[15:0] == 16'd0) ? tickCycles : int'(a[15:0]) * tickCycles;
      maxLat = minLat + tickCycles + 3;
    end
    @(posedge systemClock);
    ciStart <= 1'b1;
    ciN <= num;
    ciDataA <= a;
    ciDataB <= b;
    @(posedge systemClock);
    ciStart <= 1'b0;
    lat = 0;
    seen = 1'b0;
    while (!seen && lat < maxLat + 10) begin
      @(negedge systemClock);
      lat++;
      seen = ciDone;
    end
    assert (seen) else begin
      $display("Test %0d got no ciDone within %0d cycles of its start.", testCount, lat);
      errors++;
    end
    if (seen) begin
      assert (ciResult === expected) else begin
        $display("Fail at %0d ns: instruction %0h, expected %h, got %h",
                 $time, num, expected, ciResult);
        errors++;
      end
      assert (lat >= minLat && lat <= maxLat) else begin
        $display("Fail at %0d ns: instruction %0h answered after %0d cycles, expected %0d to %0d",
                 $time, num, lat, minLat, maxLat);
        errors++;
      end
    end
    closeTest(opName(num), errorsBefore);
  endtask

  task automatic runBurst();
    logic [31:0] expQ[$];
    int startQ[$];
    int errorsBefore;
    int edgeIdx;
    int got;
    int lat;
    logic [7:0] op;
    logic [31:0] a;
    logic [31:0] expected;
    errorsBefore = errors;
    testCount++;
    edgeIdx = 0;
    got = 0;
    fork
      begin
        for (int i = 0; i < burstLength; i++) begin
          a = $random(seed);
          op = ($random(seed) & 1) ? 8'd9 : 8'd1;
          @(posedge systemClock);
          ciStart <= 1'b1;
          ciN <= op;
          ciDataA <= a;
          ciDataB <= $random(seed);
          expQ.push_back((op == 8'd9) ? grayOf(a) : swapBytes(a));
        end
        @(posedge systemClock);
        ciStart <= 1'b0;
      end
      begin
        while (got < burstLength && edgeIdx < burstLength + 20) begin
          @(negedge systemClock);
          edgeIdx++;
          if (ciDone) begin
            got++;
            assert (startQ.size() != 0 && expQ.size() != 0) else begin
              $display("Burst got a ciDone with no start pending.");
              errors++;
            end
            if (startQ.size() != 0 && expQ.size() != 0) begin
              expected = expQ.pop_front();
              lat = edgeIdx - startQ.pop_front();
              assert (ciResult === expected && lat == 3) else begin
                $display("Fail at %0d ns: burst answer %0d, expected %h after 3, got %h after %0d",
                         $time, got, expected, ciResult, lat);
                errors++;
              end
            end
          end
          if (ciStart) begin
            startQ.push_back(edgeIdx);
          end
        end
        assert (got == burstLength) else begin
          $display("Burst got %0d answers for %0d starts.", got, burstLength);
          errors++;
        end
      end
    join
    closeTest("burst", errorsBefore);
  endtask

  initial begin
    systemClock = 1'b0;
    rstN = 1'b0;
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
    loadStim();
    if (stimLoaded) begin
      checkReset();
      for (int i = 0; i < stimNum.size(); i++) begin
        runTest(stimNum[i], stimA[i], stimB[i], stimExp[i]);
      end
      runBurst();
    end
    $display("Tests run %0d, passed %0d, failed %0d", testCount, passCount, failCount);
    if (failCount == 0 && errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Worst case is a full 16-bit delay for every test.
  initial begin
    wait (stimLoaded);
    repeat ((stimNum.size() + burstLength) * (65535 * tickCycles + 10)) begin
      @(posedge systemClock);
    end
    $display("Watchdog expired before the tests finished.");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/ciStim.txt */
# One test per line, all fields in hex.
# Columns: instruction number, operand A, operand B, expected result.
01 12345678 00000000 78563412
01 deadbeef 0000ffff efbeadde
01 000000ff 00000000 ff000000
09 0000f800 00000000 00000034
09 000007e0 00000000 000000b4
09 0000001f 00000000 00000012
09 0000ffff 00000000 000000fa
09 00000000 00000000 00000000
09 00008410 00000000 00000080
09 abcdf800 12345678 00000034
06 00000000 00000000 00000000
06 00000001 00000000 00000000
06 00000005 00000000 00000000
06 00030002 00000000 00000000
00 12345678 00000000 00000000
02 12345678 9abcdef0 00000000
07 ffffffff ffffffff 00000000
ff 00000001 00000000 00000000

/* sim.f */
common/ciPkg.sv
common/pixelPkg.sv
common/ciReqIf.sv
verilog/ciDecode.sv
ise/dataIse.sv
ise/delayIse.sv
verilog/ciMerge.sv
verilog/ciHub.sv
bench/ciHub_chk.sv
bench/ciHubTb.sv

/* Makefile */
TOP := ciHubTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
